// File: common/timer_pkg.sv
`default_nettype none

package timer_pkg;

    localparam int NUM_CHANNELS = 4;
    localparam int CH_IDX_W     = 2;
    localparam int COUNT_W      = 32;
    localparam int PRESCALE_W   = 16;

    // channel operating modes.
    typedef enum logic [1:0] {
        MODE_OFF      = 2'd0,
        MODE_ONE_SHOT = 2'd1,
        MODE_PERIODIC = 2'd2,
        MODE_PWM      = 2'd3
    } timer_mode_e;

    // writable register fields.
    typedef enum logic [2:0] {
        FIELD_CTRL     = 3'd0,
        FIELD_RELOAD   = 3'd1,
        FIELD_COMPARE  = 3'd2,
        FIELD_PRESCALE = 3'd3,
        FIELD_IRQ_MASK = 3'd4
    } cfg_field_e;

    // one config write.
    // for FIELD_CTRL, data[1:0] is the mode and data[2] requests a start.
    typedef struct packed {
        logic [CH_IDX_W-1:0] ch;
        cfg_field_e          field;
        logic [COUNT_W-1:0]  data;
    } cfg_write_t;

    typedef struct packed {
        timer_mode_e        mode;
        logic [COUNT_W-1:0] reload;
        logic [COUNT_W-1:0] compare;
    } chan_cfg_t;

    typedef struct packed {
        logic [COUNT_W-1:0] count;
        logic               running;
        logic               pwm_out;
    } chan_status_t;

endpackage

`default_nettype wire

// File: hdl/irq_collector.sv
`timescale 1ns/10ps
`default_nettype none

module irq_collector (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [timer_pkg::NUM_CHANNELS-1:0] timeout,
    input  wire logic [timer_pkg::NUM_CHANNELS-1:0] irq_mask,
    input  wire logic                               irq_clear,
    input  wire logic [timer_pkg::NUM_CHANNELS-1:0] irq_clear_mask,
    output logic [timer_pkg::NUM_CHANNELS-1:0]      irq_status,
    output logic                                    irq
);

    import timer_pkg::*;

    logic [NUM_CHANNELS-1:0] clr_bits;
    logic [NUM_CHANNELS-1:0] status_next;

    assign clr_bits = irq_clear ? irq_clear_mask : '0;

    // set wins over clear in the same cycle.
    assign status_next = (irq_status & ~clr_bits) | timeout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_status <= '0;
            irq        <= 1'b0;
        end else begin
            irq_status <= status_next;
            irq        <= |(irq_status & irq_mask);
        end
    end

endmodule

`default_nettype wire

// File: hdl/tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tick_gen (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [timer_pkg::PRESCALE_W-1:0] prescale,
    output logic                                  tick
);

    import timer_pkg::*;

    logic [PRESCALE_W-1:0] div_cnt;
    logic [PRESCALE_W-1:0] period_q;
    logic                  wrap;

    assign wrap = (div_cnt == period_q);

    // the divider value is only picked up at a wrap.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            period_q <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= wrap;
            if (wrap) begin
                div_cnt  <= '0;
                period_q <= prescale;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer_bank_top.sv
`timescale 1ns/10ps
`default_nettype none

module timer_bank_top (
    input  wire logic                                               clk,
    input  wire logic                                               rst_n,
    input  wire logic                                               cfg_valid,
    input  wire timer_pkg::cfg_write_t                              cfg,
    input  wire logic                                               irq_clear,
    input  wire logic [timer_pkg::NUM_CHANNELS-1:0]                 irq_clear_mask,
    output timer_pkg::chan_status_t [timer_pkg::NUM_CHANNELS-1:0]   status,
    output logic [timer_pkg::NUM_CHANNELS-1:0]                      timeout,
    output logic [timer_pkg::NUM_CHANNELS-1:0]                      irq_status,
    output logic                                                    irq
);

    import timer_pkg::*;

    chan_cfg_t [NUM_CHANNELS-1:0] chan_cfg;
    logic [NUM_CHANNELS-1:0]      start;
    logic [NUM_CHANNELS-1:0]      stop;
    logic [PRESCALE_W-1:0]        prescale;
    logic [NUM_CHANNELS-1:0]      irq_mask;
    logic                         tick;

    tick_gen u_tick_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .prescale (prescale),
        .tick     (tick)
    );

    timer_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg       (cfg),
        .chan_cfg  (chan_cfg),
        .start     (start),
        .stop      (stop),
        .prescale  (prescale),
        .irq_mask  (irq_mask)
    );

    // all channels share the one tick.
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        timer_channel u_chan (
            .clk      (clk),
            .rst_n    (rst_n),
            .tick     (tick),
            .chan_cfg (chan_cfg[i]),
            .start    (start[i]),
            .stop     (stop[i]),
            .status   (status[i]),
            .timeout  (timeout[i])
        );
    end

    irq_collector u_irq (
        .clk            (clk),
        .rst_n          (rst_n),
        .timeout        (timeout),
        .irq_mask       (irq_mask),
        .irq_clear      (irq_clear),
        .irq_clear_mask (irq_clear_mask),
        .irq_status     (irq_status),
        .irq            (irq)
    );

endmodule

`default_nettype wire

// File: hdl/timer_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module timer_cfg_regs (
    input  wire logic                                               clk,
    input  wire logic                                               rst_n,
    input  wire logic                                               cfg_valid,
    input  wire timer_pkg::cfg_write_t                              cfg,
    output timer_pkg::chan_cfg_t [timer_pkg::NUM_CHANNELS-1:0]      chan_cfg,
    output logic [timer_pkg::NUM_CHANNELS-1:0]                      start,
    output logic [timer_pkg::NUM_CHANNELS-1:0]                      stop,
    output logic [timer_pkg::PRESCALE_W-1:0]                        prescale,
    output logic [timer_pkg::NUM_CHANNELS-1:0]                      irq_mask
);

    import timer_pkg::*;

    timer_mode_e        mode_q    [NUM_CHANNELS];
    logic [COUNT_W-1:0] reload_q  [NUM_CHANNELS];
    logic [COUNT_W-1:0] compare_q [NUM_CHANNELS];

    logic               ctrl_wr;
    logic               reload_wr;
    logic               compare_wr;
    logic               prescale_wr;
    logic               mask_wr;
    timer_mode_e        wr_mode;
    logic               wr_start;

    // field decode.
    assign ctrl_wr     = cfg_valid && (cfg.field == FIELD_CTRL);
    assign reload_wr   = cfg_valid && (cfg.field == FIELD_RELOAD);
    assign compare_wr  = cfg_valid && (cfg.field == FIELD_COMPARE);
    assign prescale_wr = cfg_valid && (cfg.field == FIELD_PRESCALE);
    assign mask_wr     = cfg_valid && (cfg.field == FIELD_IRQ_MASK);

    assign wr_mode  = timer_mode_e'(cfg.data[1:0]);
    assign wr_start = cfg.data[2];

    // control state and the one-cycle start/stop pulses.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                mode_q[i] <= MODE_OFF;
            end
            start    <= '0;
            stop     <= '0;
            prescale <= '0;
            irq_mask <= '0;
        end else begin
            start <= '0;
            stop  <= '0;
            if (ctrl_wr) begin
                mode_q[cfg.ch] <= wr_mode;
                if (wr_mode == MODE_OFF) begin
                    stop[cfg.ch] <= 1'b1;
                end else if (wr_start) begin
                    start[cfg.ch] <= 1'b1;
                end
            end
            // global fields, channel index is don't care.
            if (prescale_wr) begin
                prescale <= cfg.data[PRESCALE_W-1:0];
            end
            if (mask_wr) begin
                irq_mask <= cfg.data[NUM_CHANNELS-1:0];
            end
        end
    end

    // reload and compare values.
    always_ff @(posedge clk) begin
        if (reload_wr) begin
            reload_q[cfg.ch] <= cfg.data;
        end
        if (compare_wr) begin
            compare_q[cfg.ch] <= cfg.data;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_cfg[i].mode    = mode_q[i];
            chan_cfg[i].reload  = reload_q[i];
            chan_cfg[i].compare = compare_q[i];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the timer bank testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wall -f src.f --top-module timer_bank_tb -o timer_bank_sim

# the log decides pass or fail, so a failing run must not stop the script here
./obj_dir/timer_bank_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: src.f
common/timer_pkg.sv
hdl/tick_gen.sv
hdl/timer_cfg_regs.sv
timer/timer_channel.sv
hdl/irq_collector.sv
hdl/timer_bank_top.sv
tests/timer_bank_tb.sv

// File: tests/timer_bank_tb.sv
`timescale 1ns/10ps
`default_nettype none

module timer_bank_tb;

    import timer_pkg::*;

    // worst period is 16 counts of 4 clocks; about a dozen periods plus slack.
    localparam int WORST_PERIOD = 16 * 4;
    localparam int WATCHDOG_NS  = 2 * (14 * WORST_PERIOD + 200) * 4;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  cfg_valid;
    cfg_write_t                            cfg;
    logic                                  irq_clear;
    logic [NUM_CHANNELS-1:0]               irq_clear_mask;
    chan_status_t [NUM_CHANNELS-1:0]       status;
    logic [NUM_CHANNELS-1:0]               timeout;
    logic [NUM_CHANNELS-1:0]               irq_status;
    logic                                  irq;

    logic [31:0] lfsr_state = 32'h1cff;

    timer_bank_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_valid      (cfg_valid),
        .cfg            (cfg),
        .irq_clear      (irq_clear),
        .irq_clear_mask (irq_clear_mask),
        .status         (status),
        .timeout        (timeout),
        .irq_status     (irq_status),
        .irq            (irq)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // expected values from the timer rules.
    function automatic int exp_period(input int reload, input int ps);
        return (reload + 1) * (ps + 1);
    endfunction

    function automatic int exp_pwm_high(input int reload, input int cmp, input int ps);
        return ((cmp < reload + 1) ? cmp : reload + 1) * (ps + 1);
    endfunction

    function automatic logic [NUM_CHANNELS-1:0] exp_sticky(
        input logic [NUM_CHANNELS-1:0] sticky,
        input logic [NUM_CHANNELS-1:0] pulses,
        input logic [NUM_CHANNELS-1:0] clr
    );
        return (sticky & ~clr) | pulses;
    endfunction

    task automatic fail_run(input string why);
        $display("%s at %0t", why, $time);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic compare_status(input string name, input chan_status_t got,
                                  input chan_status_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run("status mismatch");
        end
    endtask

    task automatic compare_bits(input string name, input logic [NUM_CHANNELS-1:0] got,
                                input logic [NUM_CHANNELS-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
            fail_run("bit mismatch");
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            fail_run("count mismatch");
        end
    endtask

    task automatic write_cfg(input int ch, input cfg_field_e field, input int data);
        @(negedge clk);
        cfg_valid = 1'b1;
        cfg.ch    = CH_IDX_W'(ch);
        cfg.field = field;
        cfg.data  = COUNT_W'(data);
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic clear_irq(input logic [NUM_CHANNELS-1:0] mask);
        @(negedge clk);
        irq_clear      = 1'b1;
        irq_clear_mask = mask;
        @(negedge clk);
        irq_clear      = 1'b0;
    endtask

    task automatic wait_timeout(input int ch, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run("no timeout pulse arrived in time");
            end
        end while (!timeout[ch]);
    endtask

    // counts timeout pulses and pwm_out high cycles of one channel over a window.
    task automatic watch_window(input int ch, input int len, output int pulses,
                                output int high);
        pulses = 0;
        high   = 0;
        repeat (len) begin
            @(negedge clk);
            pulses += int'(timeout[ch]);
            high   += int'(status[ch].pwm_out);
        end
    endtask

    // sticky status and irq model, checked every cycle.
    initial begin : irq_monitor
        logic [NUM_CHANNELS-1:0] model_status;
        logic [NUM_CHANNELS-1:0] exp_status;
        logic [NUM_CHANNELS-1:0] prev_timeout;
        logic [NUM_CHANNELS-1:0] mask_reg;
        logic [NUM_CHANNELS-1:0] old_mask;
        logic [NUM_CHANNELS-1:0] clr;
        model_status = '0;
        prev_timeout = '0;
        mask_reg     = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            clr      = irq_clear ? irq_clear_mask : '0;
            old_mask = mask_reg;
            if (cfg_valid && cfg.field == FIELD_IRQ_MASK) begin
                mask_reg = cfg.data[NUM_CHANNELS-1:0];
            end
            exp_status = exp_sticky(model_status, prev_timeout, clr);
            @(negedge clk);
            compare_bits("irq_status", irq_status, exp_status);
            compare_bits("irq", {3'b000, irq}, {3'b000, |(model_status & old_mask)});
            model_status = exp_status;
            prev_timeout = timeout;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        fail_run("watchdog expired, the tests did not finish");
    end

    initial begin : scenarios
        int ps;
        int r0;
        int r1;
        int r2;
        int c2;
        int cycles;
        int pulses;
        int high;
        int prev_count;
        int limit;
        clk            = 1'b0;
        rst_n          = 1'b0;
        cfg_valid      = 1'b0;
        cfg            = '0;
        irq_clear      = 1'b0;
        irq_clear_mask = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            compare_status($sformatf("status[%0d]", i), status[i], '0);
        end
        compare_bits("timeout", timeout, '0);
        compare_bits("irq_status", irq_status, '0);
        compare_bits("irq", {3'b000, irq}, '0);

        // nonzero prescale, so the divider really divides.
        do begin
            ps = rand_bits(2);
        end while (ps == 0);
        r0 = rand_bits(4);
        r1 = rand_bits(4);
        r2 = rand_bits(4);
        // compare inside the pwm period so both output levels show up.
        c2 = rand_bits(4) % (r2 + 1);
        limit = 2 * WORST_PERIOD + 10;
        write_cfg(0, FIELD_PRESCALE, ps);
        write_cfg(0, FIELD_IRQ_MASK, 4'b0101);

        // one-shot on channel 0.
        write_cfg(0, FIELD_RELOAD, r0);
        write_cfg(0, FIELD_CTRL, 3'b101);
        @(negedge clk);
        compare_bits("status[0].running", {3'b000, status[0].running}, 4'b0001);
        wait_timeout(0, limit, cycles);
        repeat (2) @(negedge clk);
        compare_status("status[0]", status[0], '0);
        compare_bits("irq_status", irq_status & 4'b0001, 4'b0001);
        compare_bits("irq", {3'b000, irq}, 4'b0001);
        watch_window(0, 2 * exp_period(r0, ps), pulses, high);
        compare_count("timeout[0] pulses after one-shot", pulses, 0);
        clear_irq(4'b0001);

        // periodic on channel 1, masked off.
        write_cfg(1, FIELD_RELOAD, r1);
        write_cfg(1, FIELD_CTRL, 3'b110);
        wait_timeout(1, limit, cycles);
        for (int p = 0; p < 2; p++) begin
            cycles     = 0;
            prev_count = int'(status[1].count);
            do begin
                @(negedge clk);
                cycles++;
                if (int'(status[1].count) != prev_count) begin
                    compare_count("status[1].count", int'(status[1].count),
                                  (prev_count == 0) ? r1 : prev_count - 1);
                    prev_count = int'(status[1].count);
                end
                if (cycles > limit) begin
                    fail_run("periodic channel stopped producing timeouts");
                end
            end while (!timeout[1]);
            compare_count("timeout[1] spacing", cycles, exp_period(r1, ps));
        end
        compare_bits("irq_status[1]", irq_status & 4'b0010, 4'b0010);
        compare_bits("irq", {3'b000, irq}, '0);

        // PWM on channel 2.
        write_cfg(2, FIELD_RELOAD, r2);
        write_cfg(2, FIELD_COMPARE, c2);
        write_cfg(2, FIELD_CTRL, 3'b111);
        wait_timeout(2, limit, cycles);
        watch_window(2, exp_period(r2, ps), pulses, high);
        compare_count("timeout[2] pulses per period", pulses, 1);
        compare_count("pwm_out high cycles", high, exp_pwm_high(r2, c2, ps));

        // stop channel 1 while channel 2 keeps running.
        write_cfg(1, FIELD_CTRL, 0);
        @(negedge clk);
        compare_status("status[1]", status[1], '0);
        watch_window(1, 2 * exp_period(r1, ps), pulses, high);
        compare_count("timeout[1] pulses after stop", pulses, 0);
        compare_bits("status[2].running", {3'b000, status[2].running}, 4'b0001);
        watch_window(2, exp_period(r2, ps), pulses, high);
        compare_count("timeout[2] pulses while channel 1 is off", pulses, 1);

        // clear only bit 1, then stop channel 2 and clear the rest.
        clear_irq(4'b0010);
        write_cfg(2, FIELD_CTRL, 0);
        repeat (2) @(negedge clk);
        clear_irq(4'b1111);
        repeat (2) @(negedge clk);
        compare_bits("irq_status", irq_status, '0);
        compare_bits("irq", {3'b000, irq}, '0);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: timer/timer_channel.sv
`timescale 1ns/10ps
`default_nettype none

module timer_channel (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 tick,
    input  wire timer_pkg::chan_cfg_t chan_cfg,
    input  wire logic                 start,
    input  wire logic                 stop,
    output timer_pkg::chan_status_t   status,
    output logic                      timeout
);

    import timer_pkg::*;

    logic [COUNT_W-1:0] count;
    logic               running;
    logic               pwm_out;
    timer_mode_e        act_mode;

    logic               count_zero;
    logic               reload_now;
    logic               pwm_level;

    assign count_zero = (count == '0);

    // end of a pass through zero that restarts the count.
    assign reload_now = (act_mode == MODE_PERIODIC) || (act_mode == MODE_PWM);

    // compare is read straight from the config, so a new value acts at once.
    assign pwm_level = running && (act_mode == MODE_PWM) && (count < chan_cfg.compare);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= '0;
            running  <= 1'b0;
            act_mode <= MODE_OFF;
            timeout  <= 1'b0;
            pwm_out  <= 1'b0;
        end else begin
            timeout <= 1'b0;
            pwm_out <= pwm_level;
            if (stop) begin
                count    <= '0;
                running  <= 1'b0;
                act_mode <= MODE_OFF;
            end else if (start) begin
                count    <= chan_cfg.reload;
                running  <= 1'b1;
                act_mode <= chan_cfg.mode;
            end else if (tick && running) begin
                if (!count_zero) begin
                    count <= count - 1'b1;
                end else begin
                    timeout <= 1'b1;
                    if (reload_now) begin
                        // a pending mode write takes over here.
                        count    <= chan_cfg.reload;
                        act_mode <= chan_cfg.mode;
                    end else begin
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    assign status.count   = count;
    assign status.running = running;
    assign status.pwm_out = pwm_out;

endmodule

`default_nettype wire
